//--- Makefile
# Verilator flow for the SIMD driver testbench
TOP = tb_simd_driver

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

//--- inst_semaphore.sv
// Up/down counter of issued but uncommitted instructions
// The caller must not increment while o_full is high
`default_nettype none

module inst_semaphore (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_inc,
	input  logic i_dec,
	output logic o_full,
	output logic o_empty
);

	tau_pkg::pend_cnt_t cnt;

	assign o_full  = cnt == tau_pkg::pend_cnt_t'(tau_pkg::MAX_PENDING_INST);
	assign o_empty = cnt == '0;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end else begin
			// Simultaneous inc and dec leave the count unchanged
			case ({i_inc, i_dec})
				2'b10: cnt <= cnt + tau_pkg::pend_cnt_t'(1);
				2'b01: cnt <= cnt - tau_pkg::pend_cnt_t'(1);
				default: cnt <= cnt;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- offset_stage.sv
// Walks a VDIM-dimensional A range in row-major order with unit stride
// The last dimension runs fastest
// Each dimension range must be non-empty and stay stable while i_src_rdy is high
// The source is acked together with the ack of the final position
`default_nettype none

module offset_stage (
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  logic            i_src_rdy,
	output logic            o_src_ack,
	input  tau_pkg::work_t  i_ofs_beg [tau_pkg::VDIM],
	input  tau_pkg::work_t  i_ofs_end [tau_pkg::VDIM],
	output logic            o_dst_rdy,
	input  logic            i_dst_ack,
	output tau_pkg::work_t  o_ofs [tau_pkg::VDIM],
	output tau_pkg::level_t o_beg_level,
	output tau_pkg::level_t o_end_level,
	output logic            o_islast
);

	typedef enum logic {
		S_IDLE,
		S_RUN
	} state_t;

	state_t         state;
	// Current position and its successor
	tau_pkg::work_t ofs      [tau_pkg::VDIM];
	tau_pkg::work_t ofs_nxt  [tau_pkg::VDIM];
	// Inclusive upper bound per dimension
	tau_pkg::work_t ofs_last [tau_pkg::VDIM];
	logic           beg_run;
	logic           end_run;
	logic           carry;

	// ======================================
	// Combinational
	// ======================================
	always_comb begin
		for (int d = 0; d < tau_pkg::VDIM; d++) begin
			ofs_last[d] = i_ofs_end[d] - tau_pkg::work_t'(1);
		end
	end

	// Trailing-match levels, counted from the fastest dimension
	always_comb begin
		o_beg_level = '0;
		o_end_level = '0;
		beg_run = 1'b1;
		end_run = 1'b1;
		for (int d = tau_pkg::VDIM - 1; d >= 0; d--) begin
			beg_run = beg_run && (ofs[d] == i_ofs_beg[d]);
			end_run = end_run && (ofs[d] == ofs_last[d]);
			if (beg_run)
				o_beg_level = o_beg_level + tau_pkg::level_t'(1);
			if (end_run)
				o_end_level = o_end_level + tau_pkg::level_t'(1);
		end
	end

	// Increment with carry into the slower dimensions
	always_comb begin
		carry = 1'b1;
		for (int d = tau_pkg::VDIM - 1; d >= 0; d--) begin
			ofs_nxt[d] = ofs[d];
			if (carry) begin
				if (ofs[d] == ofs_last[d]) begin
					ofs_nxt[d] = i_ofs_beg[d];
				end else begin
					ofs_nxt[d] = ofs[d] + tau_pkg::work_t'(1);
					carry = 1'b0;
				end
			end
		end
	end

	// Final position when every dimension sits at its last value
	assign o_islast  = o_end_level == tau_pkg::level_t'(tau_pkg::VDIM);
	assign o_dst_rdy = state == S_RUN;
	assign o_src_ack = o_dst_rdy && i_dst_ack && o_islast;
	assign o_ofs     = ofs;

	// ======================================
	// Sequential
	// ======================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (i_src_rdy) state <= S_RUN;
				S_RUN:  if (o_src_ack) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Position counter, loaded at job start and stepped per ack
	always_ff @(posedge i_clk) begin
		if (state == S_IDLE && i_src_rdy) begin
			ofs <= i_ofs_beg;
		end else if (o_dst_rdy && i_dst_ack) begin
			ofs <= ofs_nxt;
		end
	end

endmodule

`default_nettype wire

//--- rdyack_broadcast.sv
// Forks one rdy/ack source to two destinations
// Source fields must stay stable until o_src_ack
// Each destination sees exactly one transfer per source transfer
`default_nettype none

module rdyack_broadcast (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_src_rdy,
	output logic       o_src_ack,
	output logic [1:0] o_dst_rdys,
	input  logic [1:0] i_dst_acks
);

	// Destinations that already took the current source item
	logic [1:0] done;
	// Done flags including the acks of this cycle
	logic [1:0] done_now;

	// ======================================
	// Combinational
	// ======================================
	// Offer the item only to destinations still waiting for it
	assign o_dst_rdys = {2{i_src_rdy}} & ~done;

	// Count a destination as done once its transfer happens
	assign done_now = done | (o_dst_rdys & i_dst_acks);

	// Release the source when both sides have taken the item
	assign o_src_ack = i_src_rdy && (&done_now);

	// ======================================
	// Sequential
	// ======================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			done <= '0;
		end else if (o_src_ack) begin
			// Next source item starts with a clean slate
			done <= '0;
		end else begin
			done <= done_now;
		end
	end

endmodule

`default_nettype wire

//--- simd_driver.sv
// Instruction-issue front end of one SIMD tile
// All job fields must stay stable from i_abofs_rdy until o_abofs_ack
// Every A dimension range must be non-empty
// i_inst_commit_dval pulses once per issued instruction, never ahead of it
`default_nettype none

module simd_driver (
	input  logic              i_clk,
	input  logic              i_rst_n,
	// Job channel
	input  logic              i_abofs_rdy,
	output logic              o_abofs_ack,
	input  tau_pkg::work_t    i_bofs         [tau_pkg::VDIM],
	input  tau_pkg::work_t    i_aofs_beg     [tau_pkg::VDIM],
	input  tau_pkg::work_t    i_aofs_end     [tau_pkg::VDIM],
	input  tau_pkg::work_t    i_bgrid_step   [tau_pkg::VDIM],
	input  tau_pkg::inst_id_t i_inst_id_begs [tau_pkg::VDIM+1],
	input  tau_pkg::inst_id_t i_inst_id_ends [tau_pkg::VDIM+1],
	// Issue channel
	output logic              o_inst_rdy,
	input  logic              i_inst_ack,
	output tau_pkg::inst_id_t o_pc,
	output tau_pkg::warp_id_t o_warpid,
	output tau_pkg::work_t    o_bofs         [tau_pkg::VDIM],
	output tau_pkg::work_t    o_aofs         [tau_pkg::VDIM],
	// Commit strobe
	input  logic              i_inst_commit_dval
);

	// Job fork, bit 0 to the offset stage and bit 1 to the last-issued check
	logic              brd_src_rdy;
	logic              brd_src_ack;
	logic [1:0]        brd_dst_rdys;
	logic              s0_src_ack;
	logic              wait_last_ack;
	// Set once the fork completed and the job waits for commits
	logic              brd_fin;
	// Offset stage to warp stage
	logic              s0_dst_rdy;
	logic              s0_dst_ack;
	tau_pkg::work_t    s01_aofs [tau_pkg::VDIM];
	tau_pkg::level_t   s01_beg_level;
	tau_pkg::level_t   s01_end_level;
	tau_pkg::inst_id_t s01_id_beg;
	tau_pkg::inst_id_t s01_id_end;
	logic              s01_islast;
	logic              s01_bypass;
	logic              s01_skip;
	// Warp stage control
	logic              s1_src_rdy;
	logic              s1_src_ack;
	logic              s1_dst_rdy;
	logic              s1_islast;
	logic              inst_xfer;
	logic              inst_full;
	logic              inst_empty;

	// ======================================
	// Job completion
	// ======================================
	// Fork runs once per job, then the job waits for an empty semaphore
	assign brd_src_rdy = i_abofs_rdy && !brd_fin;
	assign o_abofs_ack = i_abofs_rdy && brd_fin && inst_empty;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			brd_fin <= 1'b0;
		end else if (o_abofs_ack) begin
			brd_fin <= 1'b0;
		end else if (brd_src_ack) begin
			brd_fin <= 1'b1;
		end
	end

	// Last item issued, or the final position dropped as empty
	assign wait_last_ack = brd_dst_rdys[1] &&
		((s01_islast && s01_skip) || (s1_islast && inst_xfer));

	// ======================================
	// Slice selection and skip gate
	// ======================================
	assign s01_id_beg = i_inst_id_begs[s01_beg_level];
	assign s01_id_end = i_inst_id_ends[s01_end_level];
	assign s01_bypass = s01_id_beg == s01_id_end;
	// Empty slices are acked here and never reach the warp stage
	// An empty final position waits until the warp stage has drained
	assign s01_skip   = s0_dst_rdy && s01_bypass && !(s01_islast && s1_dst_rdy);
	assign s1_src_rdy = s0_dst_rdy && !s01_bypass;
	assign s0_dst_ack = s01_bypass ? s01_skip : s1_src_ack;

	// ======================================
	// Stall gate
	// ======================================
	// Hold issue while the pending limit is reached
	assign o_inst_rdy = s1_dst_rdy && !inst_full;
	assign inst_xfer  = o_inst_rdy && i_inst_ack;

	// ======================================
	// Submodules
	// ======================================
	rdyack_broadcast u_brd (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (brd_src_rdy),
		.o_src_ack  (brd_src_ack),
		.o_dst_rdys (brd_dst_rdys),
		.i_dst_acks ({wait_last_ack, s0_src_ack})
	);

	offset_stage u_s0_ofs (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_src_rdy   (brd_dst_rdys[0]),
		.o_src_ack   (s0_src_ack),
		.i_ofs_beg   (i_aofs_beg),
		.i_ofs_end   (i_aofs_end),
		.o_dst_rdy   (s0_dst_rdy),
		.i_dst_ack   (s0_dst_ack),
		.o_ofs       (s01_aofs),
		.o_beg_level (s01_beg_level),
		.o_end_level (s01_end_level),
		.o_islast    (s01_islast)
	);

	warp_index_stage u_s1_idx (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_src_rdy    (s1_src_rdy),
		.o_src_ack    (s1_src_ack),
		.i_bofs       (i_bofs),
		.i_aofs       (s01_aofs),
		.i_islast     (s01_islast),
		.i_id_beg     (s01_id_beg),
		.i_id_end     (s01_id_end),
		.i_bgrid_step (i_bgrid_step),
		.o_dst_rdy    (s1_dst_rdy),
		.i_dst_ack    (inst_xfer),
		.o_pc         (o_pc),
		.o_warpid     (o_warpid),
		.o_bofs       (o_bofs),
		.o_aofs       (o_aofs),
		.o_islast     (s1_islast)
	);

	inst_semaphore u_sem_inst (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_inc   (inst_xfer),
		.i_dec   (i_inst_commit_dval),
		.o_full  (inst_full),
		.o_empty (inst_empty)
	);

endmodule

`default_nettype wire

//--- simd_driver_props.sv
// Handshake and pending-limit checks bound into simd_driver
// Pending count here mirrors issues minus commits seen on the ports
`default_nettype none

module simd_driver_props (
	input logic              i_clk,
	input logic              i_rst_n,
	input logic              i_abofs_rdy,
	input logic              i_abofs_ack,
	input tau_pkg::work_t    i_aofs_beg0,
	input tau_pkg::work_t    i_aofs_beg1,
	input tau_pkg::work_t    i_aofs_end0,
	input tau_pkg::work_t    i_aofs_end1,
	input logic              i_inst_rdy,
	input logic              i_inst_ack,
	input tau_pkg::inst_id_t i_pc,
	input tau_pkg::warp_id_t i_warpid,
	input tau_pkg::work_t    i_bofs0,
	input tau_pkg::work_t    i_bofs1,
	input tau_pkg::work_t    i_aofs0,
	input tau_pkg::work_t    i_aofs1,
	input logic              i_inst_commit_dval
);

	timeunit 1ns;
	timeprecision 1ps;

	int pend;
	// Failed assertion count, read by the testbench
	int n_fail = 0;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n)
			pend <= 0;
		else
			pend <= pend + int'(i_inst_rdy && i_inst_ack) - int'(i_inst_commit_dval);
	end

	// ========================================
	// Handshakes
	// ========================================
	// Issued item held until taken
	a_inst_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_inst_rdy && !i_inst_ack |=> i_inst_rdy && $stable(i_pc) && $stable(i_warpid)
		&& $stable(i_bofs0) && $stable(i_bofs1) && $stable(i_aofs0) && $stable(i_aofs1))
	else begin
		$error("inst item changed or withdrawn before ack");
		n_fail = n_fail + 1;
	end

	// Job request held until acked
	a_job_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_abofs_rdy && !i_abofs_ack |=> i_abofs_rdy && $stable(i_aofs_beg0)
		&& $stable(i_aofs_beg1) && $stable(i_aofs_end0) && $stable(i_aofs_end1))
	else begin
		$error("abofs job changed or withdrawn before ack");
		n_fail = n_fail + 1;
	end

	// ========================================
	// Pending limit
	// ========================================
	a_pend_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		pend >= 0 && pend <= tau_pkg::MAX_PENDING_INST)
	else begin
		$error("pending count %0d out of range", pend);
		n_fail = n_fail + 1;
	end

	a_ack_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_abofs_ack |-> pend == 0)
	else begin
		$error("job acked with %0d instructions pending", pend);
		n_fail = n_fail + 1;
	end

endmodule

bind simd_driver simd_driver_props u_props (
	.i_clk              (i_clk),
	.i_rst_n            (i_rst_n),
	.i_abofs_rdy        (i_abofs_rdy),
	.i_abofs_ack        (o_abofs_ack),
	.i_aofs_beg0        (i_aofs_beg[0]),
	.i_aofs_beg1        (i_aofs_beg[1]),
	.i_aofs_end0        (i_aofs_end[0]),
	.i_aofs_end1        (i_aofs_end[1]),
	.i_inst_rdy         (o_inst_rdy),
	.i_inst_ack         (i_inst_ack),
	.i_pc               (o_pc),
	.i_warpid           (o_warpid),
	.i_bofs0            (o_bofs[0]),
	.i_bofs1            (o_bofs[1]),
	.i_aofs0            (o_aofs[0]),
	.i_aofs1            (o_aofs[1]),
	.i_inst_commit_dval (i_inst_commit_dval)
);

`default_nettype wire

//--- sources.f
tau_pkg.sv
rdyack_broadcast.sv
offset_stage.sv
warp_index_stage.sv
inst_semaphore.sv
simd_driver.sv
simd_driver_props.sv
tb_simd_driver.sv

//--- tau_pkg.sv
// Shared widths, limits and vector types for the SIMD issue front end
// Instruction ids cover 0..N_INST so the id width is sized for N_INST+1
// Selection levels run from 0 to VDIM and must fit in level_t
`default_nettype none

package tau_pkg;

	// ======================================
	// Sizes and limits
	// ======================================
	// Number of A and B dimensions
	localparam int VDIM = 2;
	// Offset and grid step width
	localparam int WORK_BW = 16;
	// Instruction store depth
	localparam int N_INST = 16;
	// Warps issued per program counter
	localparam int MAX_WARP = 4;
	// Issued but not yet committed instructions allowed
	localparam int MAX_PENDING_INST = 4;

	// Derived widths
	localparam int INST_BW = $clog2(N_INST + 1);
	localparam int WARP_BW = $clog2(MAX_WARP);
	localparam int LEVEL_BW = $clog2(VDIM + 1);
	localparam int PEND_BW = $clog2(MAX_PENDING_INST + 1);

	// ======================================
	// Vector types
	// ======================================
	// Offset or grid step
	typedef logic [WORK_BW-1:0] work_t;
	// Instruction id or program counter
	typedef logic [INST_BW-1:0] inst_id_t;
	// Warp number within one pc
	typedef logic [WARP_BW-1:0] warp_id_t;
	// Trailing-match level, 0..VDIM
	typedef logic [LEVEL_BW-1:0] level_t;
	// Pending instruction count, 0..MAX_PENDING_INST
	typedef logic [PEND_BW-1:0] pend_cnt_t;

endpackage

`default_nettype wire

//--- tb_simd_driver.sv
// Testbench for simd_driver
// Expected items come from a model of the selection and issue rules
// The model assumes VDIM is 2 and table slices with id_beg not above id_end
// Protocol checks live in the bound simd_driver_props module
`default_nettype none

module tb_simd_driver;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_JOBS   = 5;
	localparam int PEND_MAX = tau_pkg::MAX_PENDING_INST;

	logic              i_clk;
	logic              i_rst_n;
	logic              i_abofs_rdy;
	logic              o_abofs_ack;
	tau_pkg::work_t    i_bofs         [tau_pkg::VDIM];
	tau_pkg::work_t    i_aofs_beg     [tau_pkg::VDIM];
	tau_pkg::work_t    i_aofs_end     [tau_pkg::VDIM];
	tau_pkg::work_t    i_bgrid_step   [tau_pkg::VDIM];
	tau_pkg::inst_id_t i_inst_id_begs [tau_pkg::VDIM+1];
	tau_pkg::inst_id_t i_inst_id_ends [tau_pkg::VDIM+1];
	logic              o_inst_rdy;
	logic              i_inst_ack;
	tau_pkg::inst_id_t o_pc;
	tau_pkg::warp_id_t o_warpid;
	tau_pkg::work_t    o_bofs         [tau_pkg::VDIM];
	tau_pkg::work_t    o_aofs         [tau_pkg::VDIM];
	logic              i_inst_commit_dval;

	int          seed;
	int          n_err;
	int          n_issued;
	int          n_committed;
	int          n_acks;
	int          pend;
	int          commit_wait;
	int          wd_cycles;
	// Running item count at the end of each job
	int          job_end [N_JOBS];
	logic        hold_commit;
	logic        bp_en;
	// Packed item {pc, warp, aofs0, aofs1, bofs0, bofs1}
	logic [70:0] exp_q [$];
	logic [70:0] want;

	assign pend = n_issued - n_committed;

	initial i_clk = 1'b0;
	always #10 i_clk = ~i_clk;

	simd_driver DUT (
		.i_clk              (i_clk),
		.i_rst_n            (i_rst_n),
		.i_abofs_rdy        (i_abofs_rdy),
		.o_abofs_ack        (o_abofs_ack),
		.i_bofs             (i_bofs),
		.i_aofs_beg         (i_aofs_beg),
		.i_aofs_end         (i_aofs_end),
		.i_bgrid_step       (i_bgrid_step),
		.i_inst_id_begs     (i_inst_id_begs),
		.i_inst_id_ends     (i_inst_id_ends),
		.o_inst_rdy         (o_inst_rdy),
		.i_inst_ack         (i_inst_ack),
		.o_pc               (o_pc),
		.o_warpid           (o_warpid),
		.o_bofs             (o_bofs),
		.o_aofs             (o_aofs),
		.i_inst_commit_dval (i_inst_commit_dval)
	);

	// ========================================
	// Job setup and reference model
	// ========================================
	task automatic set_fields(input int ab0, input int ae0, input int ab1, input int ae1,
		input int bo0, input int bo1, input int st0, input int st1,
		input int ib0, input int ib1, input int ib2, input int ie0, input int ie1, input int ie2);
		i_aofs_beg[0]     = tau_pkg::work_t'(ab0);
		i_aofs_end[0]     = tau_pkg::work_t'(ae0);
		i_aofs_beg[1]     = tau_pkg::work_t'(ab1);
		i_aofs_end[1]     = tau_pkg::work_t'(ae1);
		i_bofs[0]         = tau_pkg::work_t'(bo0);
		i_bofs[1]         = tau_pkg::work_t'(bo1);
		i_bgrid_step[0]   = tau_pkg::work_t'(st0);
		i_bgrid_step[1]   = tau_pkg::work_t'(st1);
		i_inst_id_begs[0] = tau_pkg::inst_id_t'(ib0);
		i_inst_id_begs[1] = tau_pkg::inst_id_t'(ib1);
		i_inst_id_begs[2] = tau_pkg::inst_id_t'(ib2);
		i_inst_id_ends[0] = tau_pkg::inst_id_t'(ie0);
		i_inst_id_ends[1] = tau_pkg::inst_id_t'(ie1);
		i_inst_id_ends[2] = tau_pkg::inst_id_t'(ie2);
	endtask

	task automatic set_job(input int j);
		case (j)
			// 3x2 range, distinct table entries
			0: set_fields(0, 3, 0, 2, 16'h0100, 16'h0200, 1, 16'h0010, 0, 1, 2, 3, 4, 5);
			// 2x3 range, three empty slices, final position among them
			1: set_fields(0, 2, 0, 3, 5, 9, 2, 3, 2, 0, 1, 2, 4, 2);
			// Offset A base, B offsets wrap at the work width
			2: set_fields(5, 7, 7, 9, 100, 16'hFFF0, 3, 16'h0010, 3, 4, 5, 6, 6, 7);
			// Single position, single pc
			3: set_fields(4, 5, 4, 5, 1, 2, 7, 7, 0, 0, 7, 0, 0, 8);
			// Single position with nothing to issue
			default: set_fields(0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 3, 0, 0, 3);
		endcase
	endtask

	// Trailing dimensions of p that match r, fastest first
	function automatic tau_pkg::level_t trail_level(input int p0, input int p1,
		input int r0, input int r1);
		if (p1 != r1)
			return 2'd0;
		if (p0 != r0)
			return 2'd1;
		return 2'd2;
	endfunction

	task automatic model_job();
		tau_pkg::level_t   bl;
		tau_pkg::level_t   el;
		tau_pkg::inst_id_t id_b;
		tau_pkg::inst_id_t id_e;
		tau_pkg::work_t    b0;
		tau_pkg::work_t    b1;
		for (int p0 = int'(i_aofs_beg[0]); p0 < int'(i_aofs_end[0]); p0++) begin
			for (int p1 = int'(i_aofs_beg[1]); p1 < int'(i_aofs_end[1]); p1++) begin
				bl = trail_level(p0, p1, int'(i_aofs_beg[0]), int'(i_aofs_beg[1]));
				el = trail_level(p0, p1, int'(i_aofs_end[0]) - 1, int'(i_aofs_end[1]) - 1);
				id_b = i_inst_id_begs[bl];
				id_e = i_inst_id_ends[el];
				// An empty slice adds no items
				for (int pc = int'(id_b); pc < int'(id_e); pc++) begin
					for (int w = 0; w < tau_pkg::MAX_WARP; w++) begin
						b0 = tau_pkg::work_t'(int'(i_bofs[0]) + w * int'(i_bgrid_step[0]));
						b1 = tau_pkg::work_t'(int'(i_bofs[1]) + w * int'(i_bgrid_step[1]));
						exp_q.push_back({tau_pkg::inst_id_t'(pc), tau_pkg::warp_id_t'(w),
							tau_pkg::work_t'(p0), tau_pkg::work_t'(p1), b0, b1});
					end
				end
			end
		end
	endtask

	// ========================================
	// Scoreboard
	// ========================================
	task automatic check_field(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			n_err++;
		end
	endtask

	always @(posedge i_clk) begin
		if (i_rst_n) begin
			if (o_inst_rdy && i_inst_ack) begin
				if (exp_q.size() == 0) begin
					$display("Instruction issued at %0d ns with none expected", $time);
					n_err++;
				end else begin
					want = exp_q.pop_front();
					check_field("pc", int'(o_pc), int'(want[70:66]));
					check_field("warpid", int'(o_warpid), int'(want[65:64]));
					check_field("aofs[0]", int'(o_aofs[0]), int'(want[63:48]));
					check_field("aofs[1]", int'(o_aofs[1]), int'(want[47:32]));
					check_field("bofs[0]", int'(o_bofs[0]), int'(want[31:16]));
					check_field("bofs[1]", int'(o_bofs[1]), int'(want[15:0]));
				end
				n_issued++;
			end
			if (i_inst_commit_dval)
				n_committed++;
			// Job ack only once all its items are issued and committed
			if (o_abofs_ack) begin
				if (n_acks >= N_JOBS) begin
					$display("Job ack at %0d ns with no job outstanding", $time);
					n_err++;
				end else if (n_issued != job_end[n_acks] || n_issued != n_committed) begin
					$display("Job %0d acked at %0d ns with work still open", n_acks, $time);
					n_err++;
				end
				n_acks++;
			end
		end
	end

	// Issue back-pressure and commit pulses, both on the falling edge
	always @(negedge i_clk) begin
		i_inst_ack = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
		i_inst_commit_dval = 1'b0;
		if (commit_wait != 0) begin
			commit_wait--;
		end else if (!hold_commit && pend > 0) begin
			i_inst_commit_dval = 1'b1;
			commit_wait = $unsigned($random(seed)) % 4;
		end
	end

	// ========================================
	// Stimulus
	// ========================================
	task automatic check_stall();
		int n;
		n = 0;
		// Commits are held, so issue must stop at the pending limit
		while (pend < PEND_MAX && n < 100) begin
			@(negedge i_clk);
			n++;
		end
		if (pend != PEND_MAX) begin
			$display("Pending count never reached the limit of %0d", PEND_MAX);
			n_err++;
		end
		repeat (6) begin
			@(posedge i_clk);
			if (o_inst_rdy) begin
				$display("Error at %0d ns: o_inst_rdy high with %0d pending", $time, PEND_MAX);
				n_err++;
			end
		end
		@(negedge i_clk);
		hold_commit = 1'b0;
		n = 0;
		do begin
			@(posedge i_clk);
			n++;
		end while (!o_inst_rdy && n < 20);
		if (!o_inst_rdy) begin
			$display("Issue did not resume after commits were released");
			n_err++;
		end
	endtask

	task automatic wait_job_ack();
		do begin
			@(posedge i_clk);
		end while (!o_abofs_ack);
	endtask

	initial begin
		seed = 38;
		n_err = 0;
		n_issued = 0;
		n_committed = 0;
		n_acks = 0;
		commit_wait = 0;
		wd_cycles = 0;
		hold_commit = 1'b1;
		bp_en = 1'b0;
		i_rst_n = 1'b0;
		i_abofs_rdy = 1'b0;
		i_inst_ack = 1'b0;
		i_inst_commit_dval = 1'b0;
		// Model every job up front, the watchdog scales with the item count
		for (int j = 0; j < N_JOBS; j++) begin
			set_job(j);
			model_job();
			job_end[j] = exp_q.size();
		end
		wd_cycles = exp_q.size() * 40 + 400;
		repeat (5) @(negedge i_clk);
		i_rst_n = 1'b1;
		// Idle outputs before any job
		repeat (4) begin
			@(posedge i_clk);
			if (o_inst_rdy || o_abofs_ack) begin
				$display("Error at %0d ns: handshake output high while idle", $time);
				n_err++;
			end
		end
		// Jobs back to back, the next one offered right after each ack
		for (int j = 0; j < N_JOBS; j++) begin
			@(negedge i_clk);
			set_job(j);
			i_abofs_rdy = 1'b1;
			bp_en = j != 0;
			if (j == 0)
				check_stall();
			wait_job_ack();
		end
		@(negedge i_clk);
		i_abofs_rdy = 1'b0;
		repeat (10) @(posedge i_clk);
		if (exp_q.size() != 0) begin
			$display("%0d expected instructions were never issued", exp_q.size());
			n_err++;
		end
		if (n_acks != N_JOBS) begin
			$display("Saw %0d job acks instead of %0d", n_acks, N_JOBS);
			n_err++;
		end
		$display("Errors: %0d scoreboard, %0d assertion", n_err, DUT.u_props.n_fail);
		if (n_err == 0 && DUT.u_props.n_fail == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog, limit set once the model has counted the items
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge i_clk);
		$display("Timeout: run did not finish within %0d cycles", wd_cycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- warp_index_stage.sv
// Expands one A position into pc x warp issue items
// Items run pc id_beg..id_end-1 outer and warp 0..MAX_WARP-1 inner
// i_bofs and i_bgrid_step are read live and must stay stable for the whole job
// id_beg must differ from id_end, empty slices are filtered upstream
`default_nettype none

module warp_index_stage (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_src_rdy,
	output logic              o_src_ack,
	input  tau_pkg::work_t    i_bofs       [tau_pkg::VDIM],
	input  tau_pkg::work_t    i_aofs       [tau_pkg::VDIM],
	input  logic              i_islast,
	input  tau_pkg::inst_id_t i_id_beg,
	input  tau_pkg::inst_id_t i_id_end,
	input  tau_pkg::work_t    i_bgrid_step [tau_pkg::VDIM],
	output logic              o_dst_rdy,
	input  logic              i_dst_ack,
	output tau_pkg::inst_id_t o_pc,
	output tau_pkg::warp_id_t o_warpid,
	output tau_pkg::work_t    o_bofs       [tau_pkg::VDIM],
	output tau_pkg::work_t    o_aofs       [tau_pkg::VDIM],
	output logic              o_islast
);

	typedef enum logic {
		S_IDLE,
		S_ISSUE
	} state_t;

	state_t            state;
	// Registered position
	tau_pkg::work_t    aofs_r   [tau_pkg::VDIM];
	logic              islast_r;
	tau_pkg::inst_id_t id_end_r;
	// Item counters
	tau_pkg::inst_id_t pc;
	tau_pkg::inst_id_t pc_nxt;
	tau_pkg::warp_id_t warp;
	// B offset of the current warp, base plus warp x step
	tau_pkg::work_t    bofs_acc [tau_pkg::VDIM];
	logic              last_pc;
	logic              last_warp;
	logic              item_last;
	logic              xfer;

	// ======================================
	// Combinational
	// ======================================
	assign pc_nxt    = pc + tau_pkg::inst_id_t'(1);
	assign last_pc   = pc_nxt == id_end_r;
	assign last_warp = warp == tau_pkg::warp_id_t'(tau_pkg::MAX_WARP - 1);
	assign item_last = last_pc && last_warp;

	assign o_dst_rdy = state == S_ISSUE;
	assign xfer      = o_dst_rdy && i_dst_ack;

	// Take a new position when idle or as the final item leaves
	assign o_src_ack = i_src_rdy && (state == S_IDLE || (xfer && item_last));

	assign o_pc     = pc;
	assign o_warpid = warp;
	assign o_bofs   = bofs_acc;
	assign o_aofs   = aofs_r;
	// Job-level last item only on the final item of the final position
	assign o_islast = islast_r && item_last;

	// ======================================
	// Sequential
	// ======================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
		end else if (o_src_ack) begin
			state <= S_ISSUE;
		end else if (xfer && item_last) begin
			state <= S_IDLE;
		end
	end

	// Position load and pc/warp stepping
	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			aofs_r   <= i_aofs;
			islast_r <= i_islast;
			id_end_r <= i_id_end;
			pc       <= i_id_beg;
			warp     <= '0;
			bofs_acc <= i_bofs;
		end else if (xfer) begin
			if (last_warp) begin
				// Next pc restarts from warp 0 at the base offset
				pc       <= pc_nxt;
				warp     <= '0;
				bofs_acc <= i_bofs;
			end else begin
				warp <= warp + tau_pkg::warp_id_t'(1);
				// One grid step per warp, no multiplier
				for (int d = 0; d < tau_pkg::VDIM; d++) begin
					bofs_acc[d] <= bofs_acc[d] + i_bgrid_step[d];
				end
			end
		end
	end

endmodule

`default_nettype wire
